//--- sms_pkg.sv
// shared constants for the console glue logic
// referenced by scoped name from the RTL and the testbench
package sms_pkg;

    // ====================
    // clock enables
    // ====================
    // one enable cycle in clk_sys ticks
    localparam int CE_PERIOD = 30;
    localparam int CE_CNT_W = 5;

    // cpu rising and falling enable phases
    localparam int CE_CPU_P_PH0 = 9;
    localparam int CE_CPU_P_PH1 = 24;
    localparam int CE_CPU_N_PH0 = 2;
    localparam int CE_CPU_N_PH1 = 17;

    // vdp runs at div5, pixel at div10
    localparam int CE_VDP_PH_LIST [6] = '{4, 9, 14, 19, 24, 29};
    localparam int CE_PIX_PH_LIST [3] = '{9, 19, 29};

    // ====================
    // cartridge download
    // ====================
    localparam int ROM_ADDR_W = 22;
    // copier header in front of the image
    localparam int ROM_HDR_BYTES = 512;
    // low 10 address bits of the last header byte
    localparam int ROM_HDR_MARK = 511;

    // ====================
    // reset and backup ram
    // ====================
    // hold counted in cpu enables, short enough to simulate
    localparam int RST_HOLD_W = 9;
    localparam int RST_HOLD_CPU = 256;

    // 16 sectors of 512 bytes for the 8k nvram
    localparam int BK_SECTORS = 16;
    localparam int BK_LBA_W = 4;
    localparam int IMG_SIZE_W = 32;

endpackage

//--- sms_ce_gen.sv
// clock enable sequencer for cpu, vdp, pixel and sprite logic
// all enables come from one 30-phase counter on clk_sys
module sms_ce_gen (
    input  logic clk_sys,
    input  logic reset_i,
    output logic ce_cpu_p_o,
    output logic ce_cpu_n_o,
    output logic ce_vdp_o,
    output logic ce_pix_o,
    output logic ce_sp_o
);

    logic [sms_pkg::CE_CNT_W-1:0] phase_q;
    int   phase_int;
    logic cpu_p_hit;
    logic cpu_n_hit;
    logic vdp_hit;
    logic pix_hit;

    // ====================
    // phase counter
    // ====================
    // wraps 29 -> 0
    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            phase_q <= '0;
        end else if (int'(phase_q) == sms_pkg::CE_PERIOD - 1) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    assign phase_int = int'(phase_q);

    // ====================
    // phase decode
    // ====================
    always_comb begin
        // cpu edges twice per period, 15 apart
        cpu_p_hit = (phase_int == sms_pkg::CE_CPU_P_PH0) ||
                    (phase_int == sms_pkg::CE_CPU_P_PH1);
        cpu_n_hit = (phase_int == sms_pkg::CE_CPU_N_PH0) ||
                    (phase_int == sms_pkg::CE_CPU_N_PH1);
        vdp_hit = 1'b0;
        pix_hit = 1'b0;
        for (int i = 0; i < $size(sms_pkg::CE_VDP_PH_LIST); i++) begin
            if (phase_int == sms_pkg::CE_VDP_PH_LIST[i]) begin
                vdp_hit = 1'b1;
            end
        end
        for (int j = 0; j < $size(sms_pkg::CE_PIX_PH_LIST); j++) begin
            if (phase_int == sms_pkg::CE_PIX_PH_LIST[j]) begin
                pix_hit = 1'b1;
            end
        end
    end

    // registered single-cycle pulses
    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            ce_cpu_p_o <= 1'b0;
            ce_cpu_n_o <= 1'b0;
            ce_vdp_o   <= 1'b0;
            ce_pix_o   <= 1'b0;
            ce_sp_o    <= 1'b0;
        end else begin
            ce_cpu_p_o <= cpu_p_hit;
            ce_cpu_n_o <= cpu_n_hit;
            ce_vdp_o   <= vdp_hit;
            ce_pix_o   <= pix_hit;
            // sprite enable toggles with counter lsb
            ce_sp_o    <= phase_q[0];
        end
    end

    // cpu rising and falling halves must stay apart
    a_cpu_edges_apart: assert property (@(posedge clk_sys) disable iff (reset_i)
        !(ce_cpu_p_o && ce_cpu_n_o))
        else $error("cpu rising and falling enables overlap");

endmodule

//--- sms_rom_loader.sv
// cartridge download path: toggle write handshake toward external memory,
// cartridge address mask, copier header detection and read address mapping
module sms_rom_loader (
    input  logic                           clk_sys,
    input  logic                           reset_i,
    input  logic                           download_i,
    input  logic                           ioctl_wr_i,
    input  logic [sms_pkg::ROM_ADDR_W-1:0] ioctl_addr_i,
    input  logic                           wr_ack_i,
    input  logic [sms_pkg::ROM_ADDR_W-1:0] rom_rd_addr_i,
    output logic                           rom_wr_o,
    output logic                           ioctl_wait_o,
    output logic [sms_pkg::ROM_ADDR_W-1:0] mem_rd_addr_o
);

    logic                           download_q;
    logic                           download_rise;
    logic [sms_pkg::ROM_ADDR_W-1:0] cart_mask_q;
    logic                           romhdr_q;
    logic [sms_pkg::ROM_ADDR_W-1:0] hdr_offset;

    // start of a new image
    assign download_rise = download_i & ~download_q;

    // ====================
    // write handshake
    // ====================
    // each strobe flips rom_wr_o, memory echoes it on wr_ack_i when done
    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            download_q   <= 1'b0;
            rom_wr_o     <= 1'b0;
            ioctl_wait_o <= 1'b0;
            cart_mask_q  <= '0;
            romhdr_q     <= 1'b0;
        end else begin
            download_q <= download_i;
            if (download_rise) begin
                // fresh image, forget old size and header
                cart_mask_q  <= '0;
                romhdr_q     <= 1'b0;
                ioctl_wait_o <= 1'b0;
            end else if (ioctl_wr_i) begin
                ioctl_wait_o <= 1'b1;
                rom_wr_o     <= ~rom_wr_o;
                // or of all addresses gives a power-of-two size mask
                cart_mask_q  <= cart_mask_q | ioctl_addr_i;
                // last byte at ...1ff means a 512 byte copier header
                romhdr_q     <= (ioctl_addr_i[9:0] == sms_pkg::ROM_HDR_MARK[9:0]);
            end else if (ioctl_wait_o && (rom_wr_o == wr_ack_i)) begin
                ioctl_wait_o <= 1'b0;
            end
        end
    end

    // ====================
    // read mapping
    // ====================
    // skip the header when present
    assign hdr_offset = romhdr_q ? sms_pkg::ROM_HDR_BYTES[sms_pkg::ROM_ADDR_W-1:0] : '0;

    // core address wrapped to image size
    always_ff @(posedge clk_sys) begin
        mem_rd_addr_o <= (rom_rd_addr_i & cart_mask_q) + hdr_offset;
    end

    // request toggle only moves in response to a write strobe
    a_wr_toggle_on_strobe: assert property (@(posedge clk_sys) disable iff (reset_i)
        !$stable(rom_wr_o) |-> $past(ioctl_wr_i))
        else $error("rom_wr_o toggled without a write strobe");

endmodule

//--- sms_reset_seq.sv
// core reset sequencer: merges user, download and backup reset sources
// and keeps the console in reset for a while after every download
module sms_reset_seq (
    input  logic clk_sys,
    input  logic reset_i,
    input  logic ce_cpu_i,
    input  logic download_i,
    input  logic user_reset_i,
    input  logic bk_reset_i,
    output logic core_reset_o
);

    logic [sms_pkg::RST_HOLD_W-1:0] hold_cnt_q;
    logic                           hold_q;

    // ====================
    // post-download hold
    // ====================
    // counts cpu enables so the hold tracks cpu time
    always_ff @(posedge clk_sys) begin
        if (reset_i || download_i) begin
            hold_q     <= 1'b1;
            hold_cnt_q <= sms_pkg::RST_HOLD_CPU[sms_pkg::RST_HOLD_W-1:0];
        end else if (ce_cpu_i) begin
            if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end else begin
                // enable that finds zero ends the hold
                hold_q <= 1'b0;
            end
        end
    end

    // ====================
    // merged reset
    // ====================
    // console starts in reset
    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            core_reset_o <= 1'b1;
        end else begin
            core_reset_o <= user_reset_i | download_i | bk_reset_i | hold_q;
        end
    end

endmodule

//--- sms_backup_sync.sv
// backup ram sync: loads or saves the 16 nvram sectors through the
// sd request/acknowledge pair, and drives the active-low activity led
module sms_backup_sync (
    input  logic                           clk_sys,
    input  logic                           reset_i,
    input  logic                           download_i,
    input  logic                           img_mounted_i,
    input  logic [sms_pkg::IMG_SIZE_W-1:0] img_size_i,
    input  logic                           save_req_i,
    input  logic                           sd_ack_i,
    output logic [sms_pkg::BK_LBA_W-1:0]   sd_lba_o,
    output logic                           sd_rd_o,
    output logic                           sd_wr_o,
    output logic                           bk_reset_o,
    output logic                           led_o
);

    // previous values for edge detection
    logic download_q;
    logic mounted_q;
    logic load_q;
    logic save_q;
    logic ack_q;

    logic bk_ena_q;
    logic bk_load_q;
    logic busy_q;
    logic last_sector;

    assign last_sector = (int'(sd_lba_o) == sms_pkg::BK_SECTORS - 1);

    // ====================
    // sector sequencer
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            download_q <= 1'b0;
            mounted_q  <= 1'b0;
            load_q     <= 1'b0;
            save_q     <= 1'b0;
            ack_q      <= 1'b0;
            bk_ena_q   <= 1'b0;
            bk_load_q  <= 1'b0;
            busy_q     <= 1'b0;
            sd_lba_o   <= '0;
            sd_rd_o    <= 1'b0;
            sd_wr_o    <= 1'b0;
            bk_reset_o <= 1'b0;
        end else begin
            // single-cycle pulse
            bk_reset_o <= 1'b0;

            download_q <= download_i;
            mounted_q  <= img_mounted_i;
            load_q     <= bk_load_q;
            save_q     <= save_req_i;
            ack_q      <= sd_ack_i;

            // new cartridge invalidates the backup image
            if (download_i && !download_q) begin
                bk_ena_q <= 1'b0;
            end

            // non-empty image mounted, pull it in
            if (img_mounted_i && !mounted_q && (img_size_i != '0)) begin
                bk_ena_q  <= 1'b1;
                bk_load_q <= 1'b1;
            end

            // sd side took the request
            if (sd_ack_i && !ack_q) begin
                sd_rd_o <= 1'b0;
                sd_wr_o <= 1'b0;
            end

            if (!busy_q) begin
                // idle, wait for load or save edge
                if (bk_ena_q && ((bk_load_q && !load_q) || (save_req_i && !save_q))) begin
                    busy_q   <= 1'b1;
                    sd_lba_o <= '0;
                    sd_rd_o  <= bk_load_q;
                    sd_wr_o  <= ~bk_load_q;
                end
            end else if (ack_q && !sd_ack_i) begin
                // sector done
                if (last_sector) begin
                    // restart the console on freshly loaded nvram
                    if (bk_load_q) begin
                        bk_reset_o <= 1'b1;
                    end
                    bk_load_q <= 1'b0;
                    busy_q    <= 1'b0;
                end else begin
                    sd_lba_o <= sd_lba_o + 1'b1;
                    sd_rd_o  <= bk_load_q;
                    sd_wr_o  <= ~bk_load_q;
                end
            end
        end
    end

    // ====================
    // activity led
    // ====================
    // on (low) while downloading or backup active
    assign led_o = ~(download_i | bk_ena_q);

    // one transfer direction at a time
    a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset_i)
        !(sd_rd_o && sd_wr_o))
        else $error("sd read and write requested together");

endmodule

//--- sms_glue_top.sv
// top level of the console glue logic
// wires clock enables, rom loader, reset and backup sync together
module sms_glue_top (
    input  logic                           clk_sys,
    input  logic                           reset_i,
    // cartridge download
    input  logic                           download_i,
    input  logic                           ioctl_wr_i,
    input  logic [sms_pkg::ROM_ADDR_W-1:0] ioctl_addr_i,
    input  logic [sms_pkg::ROM_ADDR_W-1:0] rom_rd_addr_i,
    input  logic                           wr_ack_i,
    // reset and backup requests
    input  logic                           user_reset_i,
    input  logic                           save_req_i,
    input  logic                           img_mounted_i,
    input  logic [sms_pkg::IMG_SIZE_W-1:0] img_size_i,
    input  logic                           sd_ack_i,
    // clock enables
    output logic                           ce_cpu_p_o,
    output logic                           ce_cpu_n_o,
    output logic                           ce_vdp_o,
    output logic                           ce_pix_o,
    output logic                           ce_sp_o,
    // memory side
    output logic                           rom_wr_o,
    output logic                           ioctl_wait_o,
    output logic [sms_pkg::ROM_ADDR_W-1:0] mem_rd_addr_o,
    // console and sd side
    output logic                           core_reset_o,
    output logic [sms_pkg::BK_LBA_W-1:0]   sd_lba_o,
    output logic                           sd_rd_o,
    output logic                           sd_wr_o,
    output logic                           led_o
);

    // backup load done, restart the console
    logic bk_reset;

    sms_ce_gen i_ce_gen (
        .clk_sys    (clk_sys),
        .reset_i    (reset_i),
        .ce_cpu_p_o (ce_cpu_p_o),
        .ce_cpu_n_o (ce_cpu_n_o),
        .ce_vdp_o   (ce_vdp_o),
        .ce_pix_o   (ce_pix_o),
        .ce_sp_o    (ce_sp_o)
    );

    sms_rom_loader i_rom_loader (
        .clk_sys       (clk_sys),
        .reset_i       (reset_i),
        .download_i    (download_i),
        .ioctl_wr_i    (ioctl_wr_i),
        .ioctl_addr_i  (ioctl_addr_i),
        .wr_ack_i      (wr_ack_i),
        .rom_rd_addr_i (rom_rd_addr_i),
        .rom_wr_o      (rom_wr_o),
        .ioctl_wait_o  (ioctl_wait_o),
        .mem_rd_addr_o (mem_rd_addr_o)
    );

    // hold counts cpu rising enables
    sms_reset_seq i_reset_seq (
        .clk_sys      (clk_sys),
        .reset_i      (reset_i),
        .ce_cpu_i     (ce_cpu_p_o),
        .download_i   (download_i),
        .user_reset_i (user_reset_i),
        .bk_reset_i   (bk_reset),
        .core_reset_o (core_reset_o)
    );

    sms_backup_sync i_backup_sync (
        .clk_sys       (clk_sys),
        .reset_i       (reset_i),
        .download_i    (download_i),
        .img_mounted_i (img_mounted_i),
        .img_size_i    (img_size_i),
        .save_req_i    (save_req_i),
        .sd_ack_i      (sd_ack_i),
        .sd_lba_o      (sd_lba_o),
        .sd_rd_o       (sd_rd_o),
        .sd_wr_o       (sd_wr_o),
        .bk_reset_o    (bk_reset),
        .led_o         (led_o)
    );

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset source
// 8 ns clk_sys, reset held high for the first 3 cycles
module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // release on a falling edge, like every other input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

//--- tb_sms_glue_top.sv
// testbench for the console glue logic
// drives downloads, mounts and saves, models memory and sd, checks by assertions
module tb_sms_glue_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = sms_pkg::ROM_ADDR_W;
    // three reset holds of about 3855 cycles plus the backup sequences
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk_sys, reset_i;
    logic download_i = 1'b0;
    logic ioctl_wr_i = 1'b0;
    logic wr_ack_i = 1'b0;
    logic [AW-1:0] ioctl_addr_i = '0;
    logic [AW-1:0] rom_rd_addr_i = '0;
    logic user_reset_i = 1'b0;
    logic save_req_i = 1'b0;
    logic img_mounted_i = 1'b0;
    logic sd_ack_i = 1'b0;
    logic [sms_pkg::IMG_SIZE_W-1:0] img_size_i = '0;
    logic ce_cpu_p_o, ce_cpu_n_o, ce_vdp_o, ce_pix_o, ce_sp_o;
    logic rom_wr_o, ioctl_wait_o, core_reset_o, sd_rd_o, sd_wr_o, led_o;
    logic [AW-1:0] mem_rd_addr_o;
    logic [sms_pkg::BK_LBA_W-1:0] sd_lba_o;

    logic [31:0] lcg_state = 32'h414f_ae1f;
    int fail_count = 0;
    int cycle_cnt = 0;
    // sectors seen by the sd model at each acknowledge
    logic [sms_pkg::BK_LBA_W-1:0] lba_seen[$];
    logic wr_seen[$];
    logic rd_seen[$];

    tb_clk_gen i_clk_gen (.clk_o(clk_sys), .reset_o(reset_i));

    sms_glue_top i_dut (.*);

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(int lo, int hi);
        return lo + int'(lcg_next() % (hi - lo + 1));
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(string test, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            fail_count++;
            $display("[ERROR] %s expected %0h actual %0h", test, exp, act);
            abort_run("value mismatch");
        end
    endtask

    // ====================
    // memory and sd models
    // ====================
    // ack echoes the write toggle 1 to 4 cycles later
    int mem_delay = 0;
    always @(negedge clk_sys) begin
        if (reset_i) begin
            wr_ack_i <= 1'b0;
            mem_delay = 0;
        end else if (rom_wr_o != wr_ack_i) begin
            if (mem_delay == 0) begin
                mem_delay = rand_range(1, 4);
            end
            mem_delay--;
            if (mem_delay == 0) begin
                wr_ack_i <= rom_wr_o;
            end
        end
    end

    // 0 idle, 1 delay, 2 ack high
    int sd_state = 0;
    int sd_cnt = 0;
    always @(negedge clk_sys) begin
        if (reset_i) begin
            sd_ack_i <= 1'b0;
            sd_state = 0;
        end else begin
            case (sd_state)
                0: if (sd_rd_o || sd_wr_o) begin
                    sd_cnt = rand_range(2, 5) - 1;
                    sd_state = 1;
                end
                1: if (sd_cnt == 0) begin
                    sd_ack_i <= 1'b1;
                    lba_seen.push_back(sd_lba_o);
                    wr_seen.push_back(sd_wr_o);
                    rd_seen.push_back(sd_rd_o);
                    sd_cnt = 1;
                    sd_state = 2;
                end else begin
                    sd_cnt--;
                end
                default: if (sd_cnt == 0) begin
                    sd_ack_i <= 1'b0;
                    sd_state = 0;
                end else begin
                    sd_cnt--;
                end
            endcase
        end
    end

    // ====================
    // enable spacing and timeout
    // ====================
    int last_p = -1;
    int last_n = -1;
    int last_v = -1;
    int last_x = -1;
    logic sp_prev = 1'b0;
    always @(negedge clk_sys) begin
        if (!reset_i) begin
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                abort_run("timeout: the run did not finish within the cycle limit");
            end
            if (ce_cpu_p_o) begin
                if (last_p >= 0) begin
                    check_val("ce_cpu_p spacing", sms_pkg::CE_PERIOD / 2, cycle_cnt - last_p);
                end
                last_p = cycle_cnt;
            end
            if (ce_cpu_n_o) begin
                if (last_n >= 0) begin
                    check_val("ce_cpu_n spacing", sms_pkg::CE_PERIOD / 2, cycle_cnt - last_n);
                end
                last_n = cycle_cnt;
            end
            if (ce_vdp_o) begin
                if (last_v >= 0) begin
                    check_val("ce_vdp spacing", sms_pkg::CE_PERIOD / 6, cycle_cnt - last_v);
                end
                last_v = cycle_cnt;
            end
            if (ce_pix_o) begin
                if (last_x >= 0) begin
                    check_val("ce_pix spacing", sms_pkg::CE_PERIOD / 3, cycle_cnt - last_x);
                end
                last_x = cycle_cnt;
            end
            // sprite enable follows counter bit 0 and alternates every cycle
            if (last_x >= 0) begin
                check_val("ce_sp toggle", 32'(!sp_prev), 32'(ce_sp_o));
            end
            if (ce_pix_o) begin
                // pixel phases are all odd
                check_val("ce_sp at pixel enable", 1, 32'(ce_sp_o));
            end
            sp_prev = ce_sp_o;
        end
    end

    // ====================
    // protocol assertions
    // ====================
    a_cpu_apart: assert property (@(posedge clk_sys) disable iff (reset_i)
        !(ce_cpu_p_o && ce_cpu_n_o))
        else abort_run("cpu rising and falling enables were high together");
    a_wr_toggles: assert property (@(posedge clk_sys) disable iff (reset_i)
        ioctl_wr_i |=> (rom_wr_o != $past(rom_wr_o)))
        else abort_run("rom_wr_o did not toggle after a write strobe");
    a_wait_holds: assert property (@(posedge clk_sys) disable iff (reset_i)
        (ioctl_wait_o && (rom_wr_o != wr_ack_i)) |=> ioctl_wait_o)
        else abort_run("ioctl_wait_o fell before the memory acknowledged");
    a_wait_falls: assert property (@(posedge clk_sys) disable iff (reset_i)
        (ioctl_wait_o && (rom_wr_o == wr_ack_i)) |=> !ioctl_wait_o)
        else abort_run("ioctl_wait_o stayed high after the acknowledge");
    a_sd_exclusive: assert property (@(posedge clk_sys) disable iff (reset_i)
        !(sd_rd_o && sd_wr_o))
        else abort_run("sd read and write requests were high together");
    a_user_reset: assert property (@(posedge clk_sys) disable iff (reset_i)
        user_reset_i |=> core_reset_o)
        else abort_run("user reset did not reach core_reset_o on the next cycle");

    // ====================
    // stimulus
    // ====================
    // download n random addresses and count the post-download hold
    task automatic run_download(int n, bit hdr, output logic [AW-1:0] mask);
        logic [AW-1:0] addr;
        logic prev;
        int wait_n;
        int ce_seen;
        bit first;
        mask = '0;
        download_i = 1'b1;
        repeat (2) @(negedge clk_sys);
        for (int i = 0; i < n; i++) begin
            addr = AW'(lcg_next());
            if (i == n - 1) begin
                if (hdr) addr[9:0] = 10'(sms_pkg::ROM_HDR_MARK);
                else if (addr[9:0] == 10'(sms_pkg::ROM_HDR_MARK)) addr[0] = 1'b0;
            end
            mask |= addr;
            ioctl_addr_i = addr;
            ioctl_wr_i = 1'b1;
            prev = rom_wr_o;
            @(negedge clk_sys);
            ioctl_wr_i = 1'b0;
            check_val("download toggle", 32'(!prev), 32'(rom_wr_o));
            check_val("download wait", 1, 32'(ioctl_wait_o));
            check_val("reset during download", 1, 32'(core_reset_o));
            wait_n = 0;
            while (ioctl_wait_o) begin
                @(negedge clk_sys);
                wait_n++;
                if (wait_n > 10) abort_run("ioctl_wait_o never released");
            end
            check_val("download ack", 32'(rom_wr_o), 32'(wr_ack_i));
        end
        // hold ends on the enable that finds the counter at zero
        ce_seen = 0;
        first = 1'b1;
        while (core_reset_o) begin
            if (ce_cpu_p_o) ce_seen++;
            if (first) download_i = 1'b0;
            first = 1'b0;
            @(negedge clk_sys);
        end
        check_val("reset hold", sms_pkg::RST_HOLD_CPU + 1, ce_seen);
    endtask

    task automatic check_reads(logic [AW-1:0] mask, bit hdr);
        logic [AW-1:0] addr;
        logic [AW-1:0] exp;
        for (int i = 0; i < 8; i++) begin
            addr = AW'(lcg_next());
            rom_rd_addr_i = addr;
            exp = (addr & mask) + (hdr ? AW'(sms_pkg::ROM_HDR_BYTES) : '0);
            @(negedge clk_sys);
            check_val(hdr ? "read map header" : "read map", 32'(exp), 32'(mem_rd_addr_o));
        end
    endtask

    task automatic check_sectors(string test, bit is_wr);
        check_val({test, " sector count"}, sms_pkg::BK_SECTORS, lba_seen.size());
        for (int i = 0; i < lba_seen.size(); i++) begin
            check_val({test, " sector"}, i, 32'(lba_seen[i]));
            check_val({test, " direction"}, 32'(is_wr), 32'(wr_seen[i]));
            check_val({test, " read request"}, 32'(!is_wr), 32'(rd_seen[i]));
        end
    endtask

    initial begin
        logic [AW-1:0] mask;
        int n;
        @(negedge reset_i);
        @(negedge clk_sys);
        check_val("led after reset", 1, 32'(led_o));

        // downloads with and without a copier header
        run_download(20, 1'b0, mask);
        check_reads(mask, 1'b0);
        run_download(20, 1'b1, mask);
        check_reads(mask, 1'b1);

        // user reset after release
        user_reset_i = 1'b1;
        @(negedge clk_sys);
        check_val("user reset", 1, 32'(core_reset_o));
        user_reset_i = 1'b0;
        repeat (2) @(negedge clk_sys);
        check_val("user reset release", 0, 32'(core_reset_o));

        // backup load after a mount
        lba_seen.delete();
        wr_seen.delete();
        rd_seen.delete();
        img_size_i = 32'h2000;
        img_mounted_i = 1'b1;
        @(negedge clk_sys);
        img_mounted_i = 1'b0;
        n = 0;
        while (!core_reset_o) begin
            check_val("led while enabled", 0, 32'(led_o));
            @(negedge clk_sys);
            n++;
            if (n > 500) abort_run("backup load never raised core reset");
        end
        check_sectors("backup load", 1'b0);

        // backup save
        lba_seen.delete();
        wr_seen.delete();
        rd_seen.delete();
        save_req_i = 1'b1;
        @(negedge clk_sys);
        save_req_i = 1'b0;
        n = 0;
        while (lba_seen.size() < sms_pkg::BK_SECTORS || sd_ack_i || sd_wr_o) begin
            @(negedge clk_sys);
            n++;
            if (n > 500) abort_run("backup save did not finish");
        end
        repeat (3) @(negedge clk_sys);
        check_sectors("backup save", 1'b1);

        // a new download disables the backup
        run_download(6, 1'b0, mask);
        lba_seen.delete();
        wr_seen.delete();
        rd_seen.delete();
        save_req_i = 1'b1;
        @(negedge clk_sys);
        save_req_i = 1'b0;
        repeat (40) @(negedge clk_sys);
        check_val("save after download", 0, lba_seen.size());
        check_val("led after download", 1, 32'(led_o));

        if (fail_count != 0) begin
            abort_run("checks failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- sms_glue_top.f
sms_pkg.sv
sms_ce_gen.sv
sms_rom_loader.sv
sms_reset_seq.sv
sms_backup_sync.sv
sms_glue_top.sv
tb_clk_gen.sv
tb_sms_glue_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the glue logic testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sms_glue_top -f sms_glue_top.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
